/* include/cdb_cfg.svh */
`ifndef CDB_CFG_SVH
`define CDB_CFG_SVH

// widths shared by the CDB stage and its consumers

`define CDB_XLEN 32          // data word and PC width
`define CDB_PRF_LEN 6        // physical register index width
`define CDB_ROB_LEN 5        // reorder buffer index width

// fu_ready drops once a unit result queue holds this many entries
`define CDB_QUEUE_DEPTH 2

`endif

/* hw/cdb_pkg.sv */
`default_nettype none

`include "cdb_cfg.svh"

package cdb_pkg;

    // unit number doubles as its index into the per-unit port arrays
    typedef enum logic [1:0] {
        alu = 2'd0,
        mul = 2'd1,
        mem = 2'd2,
        br  = 2'd3
    } fu_id_t;

    // branch outcome packed into one data word
    // the target PC is word aligned so its two low bits are not carried
    typedef struct packed {
        logic [`CDB_XLEN-3:0] target_word;  // target PC without the two zero bits
        logic                 taken;        // resolved direction
        logic                 mis_pred;     // prediction was wrong and fetch must redirect
    } br_info_t;

    typedef union packed {
        logic [`CDB_XLEN-1:0] value;        // result word from alu, mul and mem
        br_info_t             br;           // branch unit view of the same bits
    } cdb_payload_u;

    typedef struct packed {
        logic [`CDB_PRF_LEN-1:0] prf_idx;
        logic [`CDB_ROB_LEN-1:0] rob_idx;
        cdb_payload_u            payload;
    } fu_result_t;

    typedef struct packed {
        fu_id_t                  fu_id;     // which unit produced the result
        logic [`CDB_PRF_LEN-1:0] prf_idx;
        logic [`CDB_ROB_LEN-1:0] rob_idx;
        cdb_payload_u            payload;
    } cdb_packet_t;

endpackage

`default_nettype wire

/* hw/fu_result_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdb_cfg.svh"

module fu_result_queue (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  cdb_pkg::fu_result_t in_result,
    output logic                head_valid,
    output cdb_pkg::fu_result_t head,
    input  logic                pop
);
    import cdb_pkg::*;

    localparam int DEPTH = `CDB_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fu_result_t       entries [DEPTH];     // result storage written only on push
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             drain;

    // wrap works for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign in_ready   = (count != CNT_W'(DEPTH));    // high while not full so a unit never waits on the bus
    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];              // visible right after the push edge

    assign push  = in_valid && in_ready;
    assign drain = pop && head_valid;                 // a stray pop on an empty queue is ignored

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= in_result;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (drain) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count alone
            case ({push, drain})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic [3:0]                head_valid,
    input  cdb_pkg::fu_result_t [3:0] heads,
    input  logic                      take,
    output logic [3:0]                pop,
    output logic                      sel_valid,
    output cdb_pkg::cdb_packet_t      sel_packet
);
    import cdb_pkg::*;

    fu_id_t     win_id;    // highest priority unit with a queued result
    logic [3:0] grant;     // one-hot form of win_id, zero when nothing is queued
    fu_result_t winner;

    assign sel_valid = head_valid[alu] || head_valid[mul] || head_valid[mem] || head_valid[br];

    // fixed priority, alu over mul over mem over br
    always_comb begin
        if (head_valid[alu]) begin
            win_id = alu;
        end else if (head_valid[mul]) begin
            win_id = mul;
        end else if (head_valid[mem]) begin
            win_id = mem;
        end else begin
            win_id = br;    // also the pick when nothing is valid and then masked by sel_valid
        end
    end

    assign grant = sel_valid ? (4'b0001 << win_id) : 4'b0000;

    // the queue only advances when the broadcast register really loads
    assign pop = take ? grant : 4'b0000;

    assign winner = heads[win_id];

    always_comb begin
        sel_packet.fu_id   = win_id;             // tag with the producing unit
        sel_packet.prf_idx = winner.prf_idx;
        sel_packet.rob_idx = winner.rob_idx;
        sel_packet.payload = winner.payload;     // union passes through undecoded
    end

endmodule

`default_nettype wire

/* hw/cdb_broadcast.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdb_cfg.svh"

module cdb_broadcast (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 sel_valid,
    input  cdb_pkg::cdb_packet_t sel_packet,
    output logic                 take,
    output logic                 cdb_valid,
    input  logic                 cdb_ready,
    output cdb_pkg::cdb_packet_t cdb_packet,
    output logic                 redirect_valid,
    output logic [`CDB_XLEN-1:0] redirect_pc
);
    import cdb_pkg::*;

    br_info_t br_view;    // branch reading of the held payload
    logic     is_br;

    // room when the register is empty or its packet leaves this cycle
    assign take = !cdb_valid || cdb_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else if (take) begin
            cdb_valid <= sel_valid;    // drops when accepted with nothing behind it
        end
    end

    // packet holds steady while stalled so the consumer sees stable data
    always_ff @(posedge clock) begin
        if (take && sel_valid) begin
            cdb_packet <= sel_packet;
        end
    end

    // only a br packet carries a branch view while other units hold a plain value
    assign is_br   = (cdb_packet.fu_id == br);
    assign br_view = cdb_packet.payload.br;

    assign redirect_valid = cdb_valid && is_br && br_view.mis_pred;
    assign redirect_pc    = {br_view.target_word, 2'b00};    // restore the aligned PC

endmodule

`default_nettype wire

/* hw/cdb_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdb_cfg.svh"

module cdb_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [3:0]                fu_valid,
    output logic [3:0]                fu_ready,
    input  cdb_pkg::fu_result_t [3:0] fu_result,
    output logic                      cdb_valid,
    input  logic                      cdb_ready,
    output cdb_pkg::cdb_packet_t      cdb_packet,
    output logic                      redirect_valid,
    output logic [`CDB_XLEN-1:0]      redirect_pc
);
    import cdb_pkg::*;

    logic [3:0]          head_valid;
    fu_result_t [3:0]    heads;
    logic [3:0]          pop;
    logic                take;
    logic                sel_valid;
    cdb_packet_t         sel_packet;

    // one queue per unit whose index u matches the fu_id_t value of the unit
    for (genvar u = 0; u < 4; u++) begin : g_queue
        fu_result_queue queue_i (
            .clock      (clock),
            .rst_n      (rst_n),
            .in_valid   (fu_valid[u]),
            .in_ready   (fu_ready[u]),
            .in_result  (fu_result[u]),
            .head_valid (head_valid[u]),
            .head       (heads[u]),
            .pop        (pop[u])
        );
    end

    cdb_arbiter arbiter_i (
        .head_valid (head_valid),
        .heads      (heads),
        .take       (take),
        .pop        (pop),
        .sel_valid  (sel_valid),
        .sel_packet (sel_packet)
    );

    cdb_broadcast broadcast_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .sel_valid      (sel_valid),
        .sel_packet     (sel_packet),
        .take           (take),
        .cdb_valid      (cdb_valid),
        .cdb_ready      (cdb_ready),
        .cdb_packet     (cdb_packet),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

/* test/cdb_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_sva (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 cdb_valid,
    input logic                 cdb_ready,
    input cdb_pkg::cdb_packet_t cdb_packet,
    input logic                 redirect_valid
);
    import cdb_pkg::*;

    // a stalled packet stays on the bus unchanged until the consumer takes it
    property stall_holds;
        @(posedge clock) disable iff (!rst_n)
            (cdb_valid && !cdb_ready) |=> (cdb_valid && $stable(cdb_packet));
    endproperty

    property redirect_from_branch;
        @(posedge clock) disable iff (!rst_n)
            redirect_valid |-> (cdb_valid && cdb_packet.fu_id == br);
    endproperty

    property quiet_in_reset;
        @(posedge clock) !rst_n |-> !cdb_valid;
    endproperty

    stall_holds_a: assert property (stall_holds)
        else $error("cdb packet or valid changed while stalled");

    redirect_from_branch_a: assert property (redirect_from_branch)
        else $error("redirect raised without a valid br packet");

    quiet_in_reset_a: assert property (quiet_in_reset)
        else $error("cdb_valid high during reset");

endmodule

bind cdb_top cdb_sva sva_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .cdb_valid      (cdb_valid),
    .cdb_ready      (cdb_ready),
    .cdb_packet     (cdb_packet),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

/* test/cdb_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdb_cfg.svh"

module cdb_tb;
    import cdb_pkg::*;

    localparam int DEPTH          = `CDB_QUEUE_DEPTH;
    localparam int TIMEOUT_CYCLES = 2000;    // about five times the length of all tests

    logic                 clock;
    logic                 rst_n;
    logic [3:0]           fu_valid;
    logic [3:0]           fu_ready;
    fu_result_t [3:0]     fu_result;
    logic                 cdb_valid;
    logic                 cdb_ready;
    cdb_packet_t          cdb_packet;
    logic                 redirect_valid;
    logic [`CDB_XLEN-1:0] redirect_pc;

    cdb_packet_t exp_q [4][$];     // expected packets per unit in acceptance order
    fu_id_t      bcast_ids [$];    // unit of every accepted broadcast
    int          bcast_cycles [$];
    int          bcast_count;
    int          redirect_count;
    logic [`CDB_XLEN-1:0] last_redirect_pc;
    int          in_cycle;         // cycle of the latest input transfer
    int          cycle;
    int          watch_cycles;
    int          errors;
    int          checks;
    logic        stream_done;
    string       test_name;

    cdb_top cdb_top_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .fu_valid       (fu_valid),
        .fu_ready       (fu_ready),
        .fu_result      (fu_result),
        .cdb_valid      (cdb_valid),
        .cdb_ready      (cdb_ready),
        .cdb_packet     (cdb_packet),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #10 clock = ~clock;

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic report();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // sampled on the rising edge, before the DUT registers update
    always @(posedge clock) begin
        cdb_packet_t exp_pkt;
        cdb_packet_t in_pkt;
        logic        exp_redirect;
        if (rst_n) begin
            if (cdb_valid && cdb_ready) begin
                if (exp_q[cdb_packet.fu_id].size() == 0) begin
                    errors++;
                    $display("%s: broadcast from unit %0d at cycle %0d when none was expected",
                             test_name, cdb_packet.fu_id, cycle);
                end else begin
                    exp_pkt = exp_q[cdb_packet.fu_id].pop_front();
                    check("packet", 64'(exp_pkt), 64'(cdb_packet));
                    // only a mispredicted branch may steer fetch
                    exp_redirect = (exp_pkt.fu_id == br) && exp_pkt.payload.br.mis_pred;
                    check("redirect_valid", 64'(exp_redirect), 64'(redirect_valid));
                    if (exp_redirect) begin
                        // the target PC sits in the upper bits of a branch word
                        check("redirect_pc", 64'(exp_pkt.payload.value & ~`CDB_XLEN'(3)),
                              64'(redirect_pc));
                    end
                end
                if (redirect_valid) begin
                    redirect_count++;
                    last_redirect_pc = redirect_pc;
                end
                bcast_ids.push_back(cdb_packet.fu_id);
                bcast_cycles.push_back(cycle);
                bcast_count++;
            end
            for (int u = 0; u < 4; u++) begin
                if (fu_valid[u[1:0]] && fu_ready[u[1:0]]) begin
                    in_pkt.fu_id   = fu_id_t'(u[1:0]);
                    in_pkt.prf_idx = fu_result[u[1:0]].prf_idx;
                    in_pkt.rob_idx = fu_result[u[1:0]].rob_idx;
                    in_pkt.payload = fu_result[u[1:0]].payload;
                    exp_q[u[1:0]].push_back(in_pkt);
                    in_cycle = cycle;
                end
            end
        end
        cycle++;
    end

    initial begin
        while (watch_cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            watch_cycles++;
        end
        errors++;
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report();
    end

    function automatic fu_result_t make_result(input logic [`CDB_PRF_LEN-1:0] prf,
                                               input logic [`CDB_ROB_LEN-1:0] rob,
                                               input logic [`CDB_XLEN-1:0]    value);
        fu_result_t r;
        r.prf_idx       = prf;
        r.rob_idx       = rob;
        r.payload.value = value;
        return r;
    endfunction

    function automatic fu_result_t make_branch(input logic [`CDB_PRF_LEN-1:0] prf,
                                               input logic [`CDB_ROB_LEN-1:0] rob,
                                               input logic [`CDB_XLEN-1:0]    target,
                                               input logic                    mis_pred);
        fu_result_t r;
        r.prf_idx                   = prf;
        r.rob_idx                   = rob;
        r.payload.br.target_word    = target[`CDB_XLEN-1:2];    // word aligned target
        r.payload.br.taken          = 1'b1;
        r.payload.br.mis_pred       = mis_pred;
        return r;
    endfunction

    function automatic fu_result_t random_result();
        return make_result(`CDB_PRF_LEN'($urandom), `CDB_ROB_LEN'($urandom), $urandom);
    endfunction

    // starts and ends on a falling edge and holds valid until the queue takes it
    task automatic send_result(input fu_id_t u, input fu_result_t r, input int idle);
        fu_valid[u]  = 1'b1;
        fu_result[u] = r;
        @(posedge clock);
        while (!fu_ready[u]) begin
            @(posedge clock);
        end
        @(negedge clock);
        fu_valid[u] = 1'b0;
        repeat (idle) @(negedge clock);
    endtask

    task automatic stream_unit(input fu_id_t u, input int count, input int max_idle);
        for (int i = 0; i < count; i++) begin
            send_result(u, random_result(), $urandom_range(0, max_idle));
        end
    endtask

    task automatic wait_broadcasts(input int target, input int limit);
        int n;
        n = 0;
        while (bcast_count < target && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (bcast_count < target) begin
            errors++;
            $display("%s: missing broadcast, saw %0d of %0d", test_name, bcast_count, target);
        end
    endtask

    task automatic check_drained();
        for (int u = 0; u < 4; u++) begin
            if (exp_q[u[1:0]].size() != 0) begin
                errors++;
                $display("%s: %0d result(s) of unit %0d were never broadcast",
                         test_name, exp_q[u[1:0]].size(), u);
            end
        end
    endtask

    task automatic reset_single_pass();
        int start;
        test_name = "reset_single";
        check("cdb_valid after reset", 64'(1'b0), 64'(cdb_valid));
        check("redirect_valid after reset", 64'(1'b0), 64'(redirect_valid));
        check("fu_ready after reset", 64'(4'hf), 64'(fu_ready));
        start = bcast_count;
        send_result(alu, make_result(6'h2a, 5'h11, 32'h1234_5678), 1);
        wait_broadcasts(start + 1, 20);
        if (bcast_count > start) begin
            check("latency", 64'(2), 64'(bcast_cycles[start] - in_cycle));
        end
        check_drained();
    endtask

    task automatic priority_order();
        int start;
        test_name = "priority";
        start = bcast_count;
        fork
            send_result(br, make_branch(6'h04, 5'h04, 32'h0000_4000, 1'b0), 0);
            send_result(mem, make_result(6'h03, 5'h03, 32'hcafe_0003), 0);
            send_result(mul, make_result(6'h02, 5'h02, 32'hbeef_0002), 0);
            send_result(alu, make_result(6'h01, 5'h01, 32'hdead_0001), 0);
        join
        wait_broadcasts(start + 4, 20);
        if (bcast_count >= start + 4) begin
            for (int i = 0; i < 4; i++) begin
                check("broadcast order", 64'(i), 64'(bcast_ids[start + i]));
                check("broadcast cycle", 64'(bcast_cycles[start] + i),
                      64'(bcast_cycles[start + i]));
            end
        end
        check_drained();
    endtask

    task automatic branch_redirect();
        int start;
        int redirects;
        test_name = "redirect";
        start     = bcast_count;
        redirects = redirect_count;
        send_result(br, make_branch(6'h10, 5'h0a, 32'h8000_1234, 1'b1), 1);
        wait_broadcasts(start + 1, 20);
        check("redirects after mispredict", 64'(redirects + 1), 64'(redirect_count));
        check("redirect_pc", 64'(32'h8000_1234), 64'(last_redirect_pc));
        // the low bit of these words would read as mis_pred in the branch view
        send_result(br, make_branch(6'h11, 5'h0b, 32'h0000_2468, 1'b0), 0);
        send_result(alu, make_result(6'h12, 5'h0c, 32'h0000_0003), 0);
        send_result(mul, make_result(6'h13, 5'h0d, 32'hffff_ffff), 1);
        wait_broadcasts(start + 4, 20);
        check("redirects after clean results", 64'(redirects + 1), 64'(redirect_count));
        check_drained();
    endtask

    task automatic backpressure_stall();
        int          start;
        int          n;
        cdb_packet_t held;
        test_name = "backpressure";
        start     = bcast_count;
        cdb_ready = 1'b0;
        send_result(alu, random_result(), 0);
        n = 0;
        while (!cdb_valid && n < 10) begin
            @(negedge clock);
            n++;
        end
        if (!cdb_valid) begin
            errors++;
            $display("%s: stalled packet never reached the output", test_name);
        end
        held = cdb_packet;
        fork
            stream_unit(alu, DEPTH, 0);
            stream_unit(mul, DEPTH, 0);
            stream_unit(mem, DEPTH, 0);
            stream_unit(br, DEPTH, 0);
        join
        check("fu_ready with full queues", 64'(4'h0), 64'(fu_ready));
        repeat (5) @(negedge clock);
        check("held packet", 64'(held), 64'(cdb_packet));
        check("broadcasts while stalled", 64'(start), 64'(bcast_count));
        cdb_ready = 1'b1;
        wait_broadcasts(start + 1 + 4 * DEPTH, 40);
        repeat (3) @(negedge clock);
        check_drained();
    endtask

    task automatic random_stream();
        int start;
        test_name   = "random_stream";
        start       = bcast_count;
        stream_done = 1'b0;
        fork
            begin
                fork
                    stream_unit(alu, 50, 2);
                    stream_unit(mul, 50, 2);
                    stream_unit(mem, 50, 2);
                    stream_unit(br, 50, 2);
                join
                stream_done = 1'b1;
            end
            while (!stream_done) begin
                cdb_ready = ($urandom_range(0, 3) != 0);    // consumer stalls about a quarter of cycles
                @(negedge clock);
            end
        join
        cdb_ready = 1'b1;
        wait_broadcasts(start + 200, 100);
        repeat (3) @(negedge clock);
        check_drained();
    endtask

    initial begin
        clock            = 1'b0;
        rst_n            = 1'b1;
        fu_valid         = '0;
        fu_result        = '0;
        cdb_ready        = 1'b1;
        stream_done      = 1'b0;
        bcast_count      = 0;
        redirect_count   = 0;
        last_redirect_pc = '0;
        in_cycle         = 0;
        cycle            = 0;
        watch_cycles     = 0;
        errors           = 0;
        checks           = 0;
        test_name        = "reset";
        void'($urandom(6720));
        #2;
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        reset_single_pass();
        priority_order();
        branch_redirect();
        backpressure_stall();
        random_stream();
        repeat (5) @(negedge clock);
        report();
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hw/cdb_pkg.sv
hw/fu_result_queue.sv
hw/cdb_arbiter.sv
hw/cdb_broadcast.sv
hw/cdb_top.sv
test/cdb_sva.sv
test/cdb_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cdb_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) include/cdb_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTS FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
